// File: Makefile
TOP := fp_mul_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module fp_mul_unit

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/fp_mul_core.sv
`timescale 1ns/1ps

module fp_mul_core
    import fp_mul_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input unpacked_operands_t operands,
    input logic new_request,
    input logic advance_out,
    output logic ready,
    output mul_stage_t stage3,
    output logic stage3_valid
);

    logic advance1;
    logic advance2;
    logic advance3;
    logic valid1;
    logic valid2;

    logic rs1_nan;
    logic rs2_nan;
    logic rs1_inf;
    logic rs2_inf;
    logic rs1_zero;
    logic rs2_zero;

    mul_stage_t decode;
    mul_stage_t stage1;
    mul_stage_t stage2;
    mul_stage_t stage3_next;

    logic [2*frac_width+1:0] product;
    logic [frac_width-1:0] residual;

    ////////////////////
    // stall chain

    assign advance3 = ~stage3_valid | advance_out;
    assign advance2 = ~valid2 | advance3;
    assign advance1 = ~valid1 | advance2;
    assign ready = advance1;

    ////////////////////
    // stage 1 decode

    always_comb begin
        rs1_nan = operands.rs1_class.is_qnan | operands.rs1_class.is_snan;
        rs2_nan = operands.rs2_class.is_qnan | operands.rs2_class.is_snan;
        rs1_inf = operands.rs1_class.is_inf;
        rs2_inf = operands.rs2_class.is_inf;
        rs1_zero = operands.rs1_class.is_zero;
        rs2_zero = operands.rs2_class.is_zero;

        decode = '0;
        decode.sign = operands.rs1_sign ^ operands.rs2_sign;
        // biased sum may go negative or past 255
        decode.expo_sum = {2'b00, operands.rs1_expo} + {2'b00, operands.rs2_expo}
                          - (expo_width+2)'(bias);

        // 0 * inf or any signaling nan
        decode.invalid = (rs1_zero & rs2_inf) | (rs1_inf & rs2_zero)
                         | operands.rs1_class.is_snan | operands.rs2_class.is_snan;

        if (decode.invalid | rs1_nan | rs2_nan) begin
            decode.special = special_nan;
        end else if (rs1_inf | rs2_inf) begin
            decode.special = special_inf;
        end else if (rs1_zero | rs2_zero) begin
            decode.special = special_zero;
        end else begin
            decode.special = special_none;
        end

        decode.rm = operands.rm;
        decode.id = operands.id;
    end

    // mantissa product lands alongside stage 2
    mantissa_multiplier mantissa_mul (
        .clk(clk),
        .rst_n(rst_n),
        .advance1(advance1),
        .advance2(advance2),
        .a(operands.rs1_mant),
        .b(operands.rs2_mant),
        .product(product)
    );

    ////////////////////
    // stage 3 product split

    assign residual = product[frac_width-1:0];

    always_comb begin
        stage3_next = stage2;
        stage3_next.prod = product[2*frac_width+1:frac_width];
        // guard, round, then everything below folded into sticky
        stage3_next.grs = {residual[frac_width-1], residual[frac_width-2],
                           |residual[frac_width-3:0]};
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            stage3_valid <= 1'b0;
        end else begin
            if (advance1) begin
                valid1 <= new_request;
            end
            if (advance2) begin
                valid2 <= valid1;
            end
            if (advance3) begin
                stage3_valid <= valid2;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (advance1) begin
            stage1 <= decode;
        end
        if (advance2) begin
            stage2 <= stage1;
        end
        if (advance3) begin
            stage3 <= stage3_next;
        end
    end

endmodule

// File: hdl/fp_mul_pkg.sv
package fp_mul_pkg;

    ////////////////////
    // format

    localparam int expo_width = 8;
    localparam int frac_width = 23;
    localparam int flen = 32;
    localparam int bias = 127;

    // default quiet nan with positive sign
    localparam logic [flen-1:0] canonical_nan = 32'h7fc0_0000;

    // rounding modes in risc-v encoding
    localparam logic [2:0] rm_rne = 3'd0;
    localparam logic [2:0] rm_rtz = 3'd1;
    localparam logic [2:0] rm_rdn = 3'd2;
    localparam logic [2:0] rm_rup = 3'd3;

    // special result codes carried down the pipe
    localparam logic [1:0] special_none = 2'd0;
    localparam logic [1:0] special_inf = 2'd1;
    localparam logic [1:0] special_nan = 2'd2;
    localparam logic [1:0] special_zero = 2'd3;

    ////////////////////
    // types

    typedef logic [2:0] id_t;

    // one word, seen as raw bits or as ieee fields
    typedef union packed {
        logic [flen-1:0] raw;
        struct packed {
            logic sign;
            logic [expo_width-1:0] expo;
            logic [frac_width-1:0] frac;
        } fields;
    } fp_word_t;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_qnan;
        logic is_snan;
    } operand_class_t;

    typedef struct packed {
        fp_word_t rs1;
        fp_word_t rs2;
        logic [2:0] rm;
        id_t id;
    } fp_mul_request_t;

    // mant includes the hidden bit
    typedef struct packed {
        logic rs1_sign;
        logic [expo_width-1:0] rs1_expo;
        logic [frac_width:0] rs1_mant;
        operand_class_t rs1_class;
        logic rs2_sign;
        logic [expo_width-1:0] rs2_expo;
        logic [frac_width:0] rs2_mant;
        operand_class_t rs2_class;
        logic [2:0] rm;
        id_t id;
    } unpacked_operands_t;

    // prod is {safe, hidden, fraction}
    typedef struct packed {
        logic sign;
        logic signed [expo_width+1:0] expo_sum;
        logic [frac_width+1:0] prod;
        logic [2:0] grs;
        logic [1:0] special;
        logic invalid;
        logic [2:0] rm;
        id_t id;
    } mul_stage_t;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
        logic inexact;
    } fflags_t;

    typedef struct packed {
        logic [flen-1:0] rd;
        fflags_t flags;
        id_t id;
    } fp_mul_result_t;

endpackage

// File: hdl/fp_mul_unit.sv
`timescale 1ns/1ps

module fp_mul_unit
    import fp_mul_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input fp_mul_request_t request,
    input logic new_request,
    output logic ready,
    output fp_mul_result_t result,
    output logic done,
    input logic ack
);

    unpacked_operands_t operands;
    mul_stage_t stage3;
    logic stage3_valid;
    logic advance;

    // field split and classification
    fp_operand_unpack unpack (
        .request(request),
        .operands(operands)
    );

    // three multiply stages
    fp_mul_core core (
        .clk(clk),
        .rst_n(rst_n),
        .operands(operands),
        .new_request(new_request),
        .advance_out(advance),
        .ready(ready),
        .stage3(stage3),
        .stage3_valid(stage3_valid)
    );

    // normalize, round, writeback register
    fp_round_pack round_pack (
        .clk(clk),
        .rst_n(rst_n),
        .stage3(stage3),
        .stage3_valid(stage3_valid),
        .ack(ack),
        .advance(advance),
        .result(result),
        .done(done)
    );

endmodule

// File: hdl/fp_operand_unpack.sv
`timescale 1ns/1ps

module fp_operand_unpack
    import fp_mul_pkg::*;
(
    input fp_mul_request_t request,
    output unpacked_operands_t operands
);

    // zero exponent counts as zero, so subnormals flush here
    function automatic operand_class_t classify(fp_word_t w);
        logic expo_max;
        logic frac_zero;
        operand_class_t c;
        expo_max = &w.fields.expo;
        frac_zero = ~|w.fields.frac;
        c.is_zero = ~|w.fields.expo;
        c.is_inf = expo_max & frac_zero;
        // top fraction bit splits quiet from signaling
        c.is_qnan = expo_max & ~frac_zero & w.fields.frac[frac_width-1];
        c.is_snan = expo_max & ~frac_zero & ~w.fields.frac[frac_width-1];
        return c;
    endfunction

    fp_word_t rs1;
    fp_word_t rs2;

    assign rs1 = request.rs1;
    assign rs2 = request.rs2;

    ////////////////////
    // rs1

    always_comb begin
        operands.rs1_sign = rs1.fields.sign;
        operands.rs1_expo = rs1.fields.expo;
        // hidden bit only for nonzero exponent
        operands.rs1_mant = {|rs1.fields.expo, rs1.fields.frac};
        operands.rs1_class = classify(rs1);
    end

    ////////////////////
    // rs2

    always_comb begin
        operands.rs2_sign = rs2.fields.sign;
        operands.rs2_expo = rs2.fields.expo;
        operands.rs2_mant = {|rs2.fields.expo, rs2.fields.frac};
        operands.rs2_class = classify(rs2);
    end

    // tag and mode pass straight through
    assign operands.rm = request.rm;
    assign operands.id = request.id;

endmodule

// File: hdl/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack
    import fp_mul_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input mul_stage_t stage3,
    input logic stage3_valid,
    input logic ack,
    output logic advance,
    output fp_mul_result_t result,
    output logic done
);

    logic [frac_width:0] mant_norm;
    logic signed [expo_width+1:0] expo_norm;
    logic guard;
    logic round_bit;
    logic sticky;
    logic inexact;
    logic rne_up;
    logic round_up;
    logic [frac_width+1:0] mant_rounded;
    logic [frac_width-1:0] frac_final;
    logic signed [expo_width+1:0] expo_final;
    logic overflow_to_inf;
    fp_word_t word;
    fp_mul_result_t result_next;

    // output register empty or being taken
    assign advance = ~done | ack;

    ////////////////////
    // normalize

    always_comb begin
        if (stage3.prod[frac_width+1]) begin
            // safe bit set so shift right by one
            mant_norm = stage3.prod[frac_width+1:1];
            guard = stage3.prod[0];
            round_bit = stage3.grs[2];
            sticky = |stage3.grs[1:0];
            expo_norm = stage3.expo_sum + 10'sd1;
        end else begin
            mant_norm = stage3.prod[frac_width:0];
            guard = stage3.grs[2];
            round_bit = stage3.grs[1];
            sticky = stage3.grs[0];
            expo_norm = stage3.expo_sum;
        end
    end

    ////////////////////
    // round

    always_comb begin
        inexact = guard | round_bit | sticky;
        rne_up = guard & (round_bit | sticky | mant_norm[0]);
        case (stage3.rm)
            rm_rne: round_up = rne_up;
            rm_rtz: round_up = 1'b0;
            rm_rdn: round_up = stage3.sign & inexact;
            rm_rup: round_up = ~stage3.sign & inexact;
            default: round_up = rne_up;
        endcase

        mant_rounded = {1'b0, mant_norm} + (frac_width+2)'(round_up);
        if (mant_rounded[frac_width+1]) begin
            // carry out makes the mantissa 1.000
            frac_final = mant_rounded[frac_width:1];
            expo_final = expo_norm + 10'sd1;
        end else begin
            frac_final = mant_rounded[frac_width-1:0];
            expo_final = expo_norm;
        end

        // overflow direction per mode
        case (stage3.rm)
            rm_rtz: overflow_to_inf = 1'b0;
            rm_rdn: overflow_to_inf = stage3.sign;
            rm_rup: overflow_to_inf = ~stage3.sign;
            default: overflow_to_inf = 1'b1;
        endcase
    end

    ////////////////////
    // pack

    always_comb begin
        word = '0;
        word.fields.sign = stage3.sign;
        result_next.flags = '0;
        result_next.flags.invalid = stage3.invalid;
        result_next.id = stage3.id;

        case (stage3.special)
            special_none: begin
                if (expo_final >= 10'sd255) begin
                    result_next.flags.overflow = 1'b1;
                    result_next.flags.inexact = 1'b1;
                    if (overflow_to_inf) begin
                        word.fields.expo = '1;
                    end else begin
                        // largest finite
                        word.fields.expo = 8'hfe;
                        word.fields.frac = '1;
                    end
                end else if (expo_final <= 10'sd0) begin
                    // flush to signed zero
                    result_next.flags.underflow = 1'b1;
                    result_next.flags.inexact = 1'b1;
                end else begin
                    word.fields.expo = expo_final[expo_width-1:0];
                    word.fields.frac = frac_final;
                    result_next.flags.inexact = inexact;
                end
            end
            special_inf: word.fields.expo = '1;
            special_nan: word.raw = canonical_nan;
            default: word.fields.expo = '0;
        endcase

        result_next.rd = word.raw;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= stage3_valid;
        end
    end

    // result register holds while done and no ack
    always_ff @(posedge clk) begin
        if (advance) begin
            result <= result_next;
        end
    end

endmodule

// File: hdl/mantissa_multiplier.sv
`timescale 1ns/1ps

module mantissa_multiplier (
    input logic clk,
    input logic rst_n,
    input logic advance1,
    input logic advance2,
    input logic [23:0] a,
    input logic [23:0] b,
    output logic [47:0] product
);

    logic [23:0] a_q;
    logic [23:0] b_q;

    // stage 1 operand registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (advance1) begin
            a_q <= a;
            b_q <= b;
        end
    end

    // stage 2 full 48 bit product
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            product <= '0;
        end else if (advance2) begin
            product <= a_q * b_q;
        end
    end

endmodule

// File: testbench/fp_mul_unit_tb.sv
`timescale 1ns/1ps

module fp_mul_unit_tb
    import fp_mul_pkg::*;
();

    localparam int wait_limit = 60;

    logic clk;
    logic rst_n;
    fp_mul_request_t request;
    logic new_request;
    logic ready;
    fp_mul_result_t result;
    logic done;
    logic ack;

    fp_mul_result_t expected_q [$];
    logic [31:0] pair_a [16];
    logic [31:0] pair_b [16];
    logic [15:0] lfsr_state;
    id_t next_id;
    int errors = 0;
    int results_seen = 0;
    int tests_run = 0;
    int tests_failed = 0;

    tb_clock_gen clock_gen (
        .clk(clk),
        .rst_n(rst_n)
    );

    fp_mul_unit UUT (
        .clk(clk),
        .rst_n(rst_n),
        .request(request),
        .new_request(new_request),
        .ready(ready),
        .result(result),
        .done(done),
        .ack(ack)
    );

    ////////////////////
    // stimulus helpers

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_normal(input int expo_base);
        logic [31:0] bits;
        logic [31:0] w;
        bits = take_bits(1);
        w[31] = bits[0];
        bits = take_bits(6);
        w[30:23] = 8'(expo_base + int'(bits));
        bits = take_bits(23);
        w[22:0] = bits[22:0];
        return w;
    endfunction

    // short fractions so the product fits without rounding
    function automatic logic [31:0] random_exact();
        logic [31:0] bits;
        logic [31:0] w;
        bits = take_bits(1);
        w[31] = bits[0];
        bits = take_bits(5);
        w[30:23] = 8'(112 + int'(bits));
        bits = take_bits(4);
        w[22:0] = {bits[3:0], 19'h0};
        return w;
    endfunction

    ////////////////////
    // reference model

    function automatic fp_mul_result_t model_multiply(input logic [31:0] a,
                                                      input logic [31:0] b,
                                                      input logic [2:0] rm);
        fp_mul_result_t r;
        logic sign;
        logic a_zero, a_inf, a_nan, a_snan;
        logic b_zero, b_inf, b_nan, b_snan;
        logic [47:0] p;
        logic [24:0] m;
        logic g, st, up, to_inf;
        int ea, eb, e, sh;
        r = '0;
        sign = a[31] ^ b[31];
        ea = int'(a[30:23]);
        eb = int'(b[30:23]);
        // exponent zero reads as zero with subnormals included
        a_zero = (ea == 0);
        a_inf = (ea == 255) && (a[22:0] == 23'h0);
        a_nan = (ea == 255) && (a[22:0] != 23'h0);
        a_snan = a_nan && !a[22];
        b_zero = (eb == 0);
        b_inf = (eb == 255) && (b[22:0] == 23'h0);
        b_nan = (eb == 255) && (b[22:0] != 23'h0);
        b_snan = b_nan && !b[22];
        r.flags.invalid = (a_zero && b_inf) || (a_inf && b_zero) || a_snan || b_snan;
        if (r.flags.invalid || a_nan || b_nan) begin
            r.rd = 32'h7fc0_0000;
        end else if (a_inf || b_inf) begin
            r.rd = {sign, 8'hff, 23'h0};
        end else if (a_zero || b_zero) begin
            r.rd = {sign, 31'h0};
        end else begin
            p = {24'h0, 1'b1, a[22:0]} * {24'h0, 1'b1, b[22:0]};
            sh = p[47] ? 24 : 23;
            e = ea + eb - 127 + sh - 23;
            m = 25'(p >> sh);
            g = p[sh-1];
            st = (p & ((48'h1 << (sh - 1)) - 48'h1)) != 48'h0;
            case (rm)
                rm_rtz: up = 1'b0;
                rm_rdn: up = sign && (g || st);
                rm_rup: up = !sign && (g || st);
                default: up = g && (st || m[0]);
            endcase
            m = m + 25'(up);
            if (m[24]) begin
                m = m >> 1;
                e = e + 1;
            end
            if (e >= 255) begin
                r.flags.overflow = 1'b1;
                r.flags.inexact = 1'b1;
                to_inf = (rm == rm_rdn) ? sign
                       : (rm == rm_rup) ? !sign
                       : (rm != rm_rtz);
                r.rd = to_inf ? {sign, 8'hff, 23'h0} : {sign, 8'hfe, 23'h7fffff};
            end else if (e <= 0) begin
                r.flags.underflow = 1'b1;
                r.flags.inexact = 1'b1;
                r.rd = {sign, 31'h0};
            end else begin
                r.flags.inexact = g || st;
                r.rd = {sign, 8'(e), m[22:0]};
            end
        end
        return r;
    endfunction

    ////////////////////
    // drive and collect

    // holds new_request until ready was seen and then queues the expected result
    task automatic issue_request(input logic [31:0] a, input logic [31:0] b,
                                 input logic [2:0] rm, input logic [31:0] rd_exp,
                                 input fflags_t flags_exp);
        fp_mul_result_t exp_r;
        logic taken;
        int cycles;
        request.rs1.raw = a;
        request.rs2.raw = b;
        request.rm = rm;
        request.id = next_id;
        new_request = 1'b1;
        taken = 1'b0;
        cycles = 0;
        while (!taken && cycles < wait_limit) begin
            @(negedge clk);
            taken = ready;
            @(posedge clk);
            #1;
            cycles++;
        end
        new_request = 1'b0;
        if (taken) begin
            exp_r.rd = rd_exp;
            exp_r.flags = flags_exp;
            exp_r.id = next_id;
            expected_q.push_back(exp_r);
            next_id = next_id + 3'd1;
        end else begin
            $display("timeout: request id %0d was never accepted", next_id);
            errors++;
        end
    endtask

    task automatic issue_with_model(input logic [31:0] a, input logic [31:0] b,
                                    input logic [2:0] rm);
        fp_mul_result_t r;
        r = model_multiply(a, b, rm);
        issue_request(a, b, rm, r.rd, r.flags);
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while (expected_q.size() != 0 && cycles < wait_limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (expected_q.size() != 0) begin
            $display("timeout: %0d results never arrived", expected_q.size());
            errors++;
            expected_q.delete();
        end
        // room for a stray duplicate to show up
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // every consumed result is compared in order
    always @(negedge clk) begin : check_results
        fp_mul_result_t exp_r;
        if (rst_n && done && ack) begin
            if (expected_q.size() == 0) begin
                $display("unexpected result with id %0d at %0t, nothing was pending",
                         result.id, $time);
                errors++;
            end else begin
                exp_r = expected_q.pop_front();
                results_seen++;
                if (result !== exp_r) begin
                    $display({"mismatch at %0t: id %0d rd %h flags %b,",
                              " expected id %0d rd %h flags %b"},
                             $time, result.id, result.rd, result.flags,
                             exp_r.id, exp_r.rd, exp_r.flags);
                    errors++;
                end
            end
        end
    end

    ////////////////////
    // tests

    task automatic reset_and_latency();
        int errors_before;
        int latency;
        logic seen;
        errors_before = errors;
        @(negedge clk);
        if (done !== 1'b0 || ready !== 1'b1) begin
            $display("mismatch at %0t: after reset done %b ready %b", $time, done, ready);
            errors++;
        end
        @(posedge clk);
        #1;
        // 1.5 * 2.0 = 3.0
        issue_request(32'h3fc0_0000, 32'h4000_0000, rm_rne, 32'h4040_0000, 4'b0000);
        latency = 0;
        seen = 1'b0;
        while (!seen && latency < wait_limit) begin
            latency++;
            @(negedge clk);
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
        if (!seen) begin
            $display("timeout: done never rose for the single request");
            errors++;
        end else if (latency != 4) begin
            $display("mismatch at %0t: latency %0d cycles, expected 4", $time, latency);
            errors++;
        end
        @(posedge clk);
        #1;
        drain_results();
        report_test("reset and latency", errors_before);
    endtask

    task automatic random_rne_stream();
        int errors_before;
        errors_before = errors;
        for (int i = 0; i < 16; i++) begin
            if (i % 4 == 3) begin
                pair_a[i] = random_exact();
                pair_b[i] = random_exact();
            end else begin
                pair_a[i] = random_normal(96);
                pair_b[i] = random_normal(96);
            end
            issue_with_model(pair_a[i], pair_b[i], rm_rne);
        end
        drain_results();
        report_test("random rne stream", errors_before);
    endtask

    // pairs 3, 7, 11 and 15 are exact so inexact must stay low there
    task automatic other_rounding_modes();
        int errors_before;
        errors_before = errors;
        for (int m = 1; m < 4; m++) begin
            for (int i = 0; i < 16; i++) begin
                issue_with_model(pair_a[i], pair_b[i], 3'(m));
            end
        end
        drain_results();
        report_test("rtz rdn rup", errors_before);
    endtask

    task automatic special_operands();
        int errors_before;
        errors_before = errors;
        issue_request(32'h7fd0_0000, 32'h3f80_0000, rm_rne, 32'h7fc0_0000, 4'b0000);
        issue_request(32'h7f80_0001, 32'h4000_0000, rm_rne, 32'h7fc0_0000, 4'b1000);
        issue_request(32'h7f80_0000, 32'h0000_0000, rm_rtz, 32'h7fc0_0000, 4'b1000);
        issue_request(32'h8000_0000, 32'hff80_0000, rm_rne, 32'h7fc0_0000, 4'b1000);
        issue_request(32'h7f80_0000, 32'hc000_0000, rm_rup, 32'hff80_0000, 4'b0000);
        issue_request(32'hff80_0000, 32'hff80_0000, rm_rdn, 32'h7f80_0000, 4'b0000);
        issue_request(32'h0000_0000, 32'hc040_0000, rm_rne, 32'h8000_0000, 4'b0000);
        // subnormals behave as zero
        issue_request(32'h0000_0123, 32'h4000_0000, rm_rne, 32'h0000_0000, 4'b0000);
        issue_request(32'h8040_0000, 32'h40a0_0000, rm_rup, 32'h8000_0000, 4'b0000);
        issue_request(32'h0040_0000, 32'h7f80_0000, rm_rne, 32'h7fc0_0000, 4'b1000);
        issue_request(32'hffc0_0000, 32'h7f80_0000, rm_rne, 32'h7fc0_0000, 4'b0000);
        issue_request(32'h7fa0_0000, 32'h7fc0_0000, rm_rne, 32'h7fc0_0000, 4'b1000);
        drain_results();
        report_test("special operands", errors_before);
    endtask

    task automatic overflow_underflow();
        int errors_before;
        errors_before = errors;
        // 2^127 * 2 in each mode and sign
        issue_request(32'h7f00_0000, 32'h4000_0000, rm_rne, 32'h7f80_0000, 4'b0101);
        issue_request(32'h7f00_0000, 32'hc000_0000, rm_rne, 32'hff80_0000, 4'b0101);
        issue_request(32'h7f00_0000, 32'h4000_0000, rm_rtz, 32'h7f7f_ffff, 4'b0101);
        issue_request(32'h7f00_0000, 32'hc000_0000, rm_rtz, 32'hff7f_ffff, 4'b0101);
        issue_request(32'h7f00_0000, 32'h4000_0000, rm_rdn, 32'h7f7f_ffff, 4'b0101);
        issue_request(32'h7f00_0000, 32'hc000_0000, rm_rdn, 32'hff80_0000, 4'b0101);
        issue_request(32'h7f00_0000, 32'h4000_0000, rm_rup, 32'h7f80_0000, 4'b0101);
        issue_request(32'h7f00_0000, 32'hc000_0000, rm_rup, 32'hff7f_ffff, 4'b0101);
        // smallest normal times one half
        issue_request(32'h0080_0000, 32'h3f00_0000, rm_rne, 32'h0000_0000, 4'b0011);
        issue_request(32'h8080_0000, 32'h3f00_0000, rm_rup, 32'h8000_0000, 4'b0011);
        for (int i = 0; i < 4; i++) begin
            issue_with_model(random_normal(190), random_normal(190), 3'(i));
            issue_with_model(random_normal(1), random_normal(1), 3'(i));
        end
        drain_results();
        report_test("overflow and underflow", errors_before);
    endtask

    task automatic back_pressure();
        int errors_before;
        int seen_before;
        logic [31:0] a;
        logic [31:0] b;
        fp_mul_result_t held;
        errors_before = errors;
        seen_before = results_seen;
        ack = 1'b0;
        for (int i = 0; i < 4; i++) begin
            issue_with_model(random_normal(100), random_normal(100), rm_rne);
        end
        // fifth request waits while all four stages are full
        a = random_normal(100);
        b = random_normal(100);
        request.rs1.raw = a;
        request.rs2.raw = b;
        request.rm = rm_rup;
        request.id = next_id;
        new_request = 1'b1;
        @(negedge clk);
        held = result;
        for (int i = 0; i < 6; i++) begin
            if (ready !== 1'b0) begin
                $display("mismatch at %0t: ready high with every stage full", $time);
                errors++;
            end
            if (done !== 1'b1 || result !== held) begin
                $display("mismatch at %0t: result not held, done %b rd %h", $time,
                         done, result.rd);
                errors++;
            end
            @(posedge clk);
            #1;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ack = 1'b1;
        issue_with_model(a, b, rm_rup);
        drain_results();
        if (results_seen - seen_before != 5) begin
            $display("mismatch at %0t: %0d results drained, expected 5", $time,
                     results_seen - seen_before);
            errors++;
        end
        report_test("back-pressure", errors_before);
    endtask

    initial begin
        request = '0;
        new_request = 1'b0;
        ack = 1'b1;
        lfsr_state = 16'd46;
        next_id = '0;
        wait_for_reset();
        reset_and_latency();
        random_rne_stream();
        other_rounding_modes();
        special_operands();
        overflow_underflow();
        back_pressure();
        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// File: verilog.f
hdl/fp_mul_pkg.sv
hdl/fp_operand_unpack.sv
hdl/mantissa_multiplier.sv
hdl/fp_mul_core.sv
hdl/fp_round_pack.sv
hdl/fp_mul_unit.sv
testbench/tb_clock_gen.sv
testbench/fp_mul_unit_tb.sv
